// File: bench/tb_entropy_out.sv
// directed testbench that runs as the simulation top for the entropy output stage
`timescale 1ns/1ps
`default_nettype none

`include "stuffer_macros.svh"

module tb_entropy_out import stuffer_pkg::*; ();
    logic         xclk;
    logic         rst;
    code_in_t     code;
    logic         code_stb;
    logic         flush_in;
    packed_word_t esc_word;
    logic         dv;
    logic         flush_out;

    bit           exp_bits[$];   // model bit stream with the MSB first
    logic [7:0]   got_bytes[$];  // bytes collected from the DUT
    int           flush_cnt;
    int           words;
    int           part_words;    // dv words with nbytes != 0
    logic [1:0]   last_nbytes;
    int           errors;
    int           test_errs;     // error count when the test began
    int           tests_run;
    int           tests_failed;
    bit           timed_out;
    logic [31:0]  lfsr;
    string        cur_test;

    entropy_out_top entropy_out_top_inst (
        .xclk      (xclk),
        .rst       (rst),
        .code      (code),
        .code_stb  (code_stb),
        .flush_in  (flush_in),
        .esc_word  (esc_word),
        .dv        (dv),
        .flush_out (flush_out)
    );

    always #10 xclk = ~xclk;

    // registered outputs are settled at the falling edge
    always @(negedge xclk) begin : monitor
        int n;
        if (rst === 1'b0 && flush_out === 1'b1) begin
            flush_cnt++;
        end
        if (rst === 1'b0 && dv === 1'b1) begin
            if (flush_cnt != 0) begin
                errors++;
                $display("%s: dv came with or after flush_out", cur_test);
            end
            n = (esc_word.nbytes == 2'd0) ? 4 : int'(esc_word.nbytes);
            for (int k = 0; k < n; k++) begin
                got_bytes.push_back(esc_word.data[31-8*k -: 8]);
            end
            words++;
            if (esc_word.nbytes != 2'd0) begin
                part_words++;
            end
            last_nbytes = esc_word.nbytes;
        end
    end

    // galois LFSR with taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == test_errs) begin
            $display("%s passed", cur_test);
        end else begin
            tests_failed++;
            $display("%s failed, %0d errors", cur_test, errors - test_errs);
        end
    endtask

    task automatic start_stream();
        exp_bits.delete();
        got_bytes.delete();
        flush_cnt  = 0;
        words      = 0;
        part_words = 0;
    endtask

    task automatic send_code(input logic [15:0] bits, input int len);
        @(negedge xclk);
        code.bits = bits;
        code.len  = `LEN_W'(len);
        code_stb  = 1'b1;
        for (int i = len - 1; i >= 0; i--) begin
            exp_bits.push_back(bits[i]);   // MSB goes out first
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge xclk);
            code_stb = 1'b0;
        end
    endtask

    task automatic check_quiet();
        if (dv !== 1'b0) begin
            errors++;
            $display("ERR dv got %h expected 0", dv);
        end
        if (flush_out !== 1'b0) begin
            errors++;
            $display("ERR flush_out got %h expected 0", flush_out);
        end
    endtask

    // reference model pads with ones and puts a zero after every 0xFF
    task automatic check_stream();
        logic [7:0] exp_bytes[$];
        logic [7:0] b;
        int         first_bad;
        while (exp_bits.size() % 8 != 0) begin
            exp_bits.push_back(1'b1);
        end
        for (int i = 0; i < exp_bits.size(); i += 8) begin
            for (int j = 0; j < 8; j++) begin
                b[7-j] = exp_bits[i+j];
            end
            exp_bytes.push_back(b);
            if (b == 8'hff) begin
                exp_bytes.push_back(8'h00);
            end
        end
        if (got_bytes.size() != exp_bytes.size()) begin
            errors++;
            $display("%s: got %0d stream bytes but expected %0d", cur_test,
                     got_bytes.size(), exp_bytes.size());
        end
        first_bad = -1;
        for (int i = 0; i < got_bytes.size() && i < exp_bytes.size(); i++) begin
            if (first_bad < 0 && got_bytes[i] !== exp_bytes[i]) begin
                first_bad = i;
            end
        end
        if (first_bad >= 0) begin
            errors++;
            $display("ERR esc_word byte %0d got %02h expected %02h", first_bad,
                     got_bytes[first_bad], exp_bytes[first_bad]);
        end
        if (words > 0 && last_nbytes !== 2'(exp_bytes.size() % 4)) begin
            errors++;
            $display("ERR esc_word.nbytes got %h expected %h", last_nbytes,
                     2'(exp_bytes.size() % 4));
        end
        if (flush_cnt != 1) begin
            errors++;
            $display("%s: flush_out pulsed %0d times instead of once", cur_test, flush_cnt);
        end
    endtask

    task automatic finish_stream();
        int cyc;
        @(negedge xclk);
        code_stb = 1'b0;
        flush_in = 1'b1;
        @(negedge xclk);
        flush_in = 1'b0;
        cyc      = 0;
        while (flush_cnt == 0 && cyc < `WAIT_LIMIT) begin
            @(posedge xclk);
            cyc++;
        end
        if (flush_cnt == 0) begin
            errors++;
            timed_out = 1'b1;
            $display("%s: no flush_out within %0d cycles", cur_test, `WAIT_LIMIT);
        end else begin
            repeat (4) @(negedge xclk);   // catch stray words or pulses
            check_stream();
        end
    endtask

    task automatic reset_quiet();
        begin_test("reset_state");
        repeat (10) begin
            @(negedge xclk);
            check_quiet();
        end
        rst = 1'b0;
        repeat (3) begin
            @(negedge xclk);
            check_quiet();
        end
        start_stream();
        finish_stream();   // empty stream gives only flush_out
        end_test();
    endtask

    task automatic plain_bytes();
        begin_test("no_ff");
        start_stream();
        for (int i = 0; i < 16; i++) begin
            send_code(16'h1000 + 16'(i) * 16'h0123, 16);
        end
        finish_stream();
        if (part_words != 0) begin
            errors++;
            $display("%s: %0d words carried a partial byte count", cur_test, part_words);
        end
        end_test();
    endtask

    task automatic lane_escapes();
        logic [15:0] codes [8] = '{16'hff12, 16'h3456, 16'h12ff, 16'h3456,
                                   16'h1234, 16'hff56, 16'h1234, 16'h56ff};
        begin_test("lane_escapes");
        start_stream();
        for (int i = 0; i < 8; i++) begin
            send_code(codes[i], 16);
        end
        finish_stream();
        end_test();
    endtask

    task automatic boundary_escapes();
        logic [15:0] vals [10] = '{16'h1234, 16'hffff, 16'hffff, 16'h5678, 16'h00ab,
                                   16'hffff, 16'hffff, 16'h00ff, 16'hffff, 16'h0011};
        int          lens [10] = '{16, 16, 16, 16, 8, 16, 16, 8, 16, 16};
        begin_test("boundary_ff");
        start_stream();
        for (int i = 0; i < 10; i++) begin
            send_code(vals[i], lens[i]);
        end
        finish_stream();
        end_test();
    endtask

    task automatic partial_flush();
        begin_test("partial_flush");
        start_stream();
        send_code(16'h0000, 1);
        finish_stream();
        start_stream();
        send_code(16'h0007, 3);   // padding turns this into 0xFF
        finish_stream();
        start_stream();
        send_code(16'h1234, 16);
        send_code(16'h2aaa, 15);
        finish_stream();
        start_stream();
        send_code(16'habcd, 16);
        send_code(16'h0102, 16);
        send_code(16'h01ff, 9);
        finish_stream();
        start_stream();
        send_code(16'h0055, 7);
        send_code(16'h002a, 6);
        finish_stream();
        end_test();
    endtask

    task automatic random_stream();
        logic [15:0] bits;
        int          len;
        begin_test("random_stream");
        start_stream();
        for (int i = 0; i < 300; i++) begin
            len  = int'(take_bits(4)) + 1;
            bits = 16'(take_bits(len));
            send_code(bits, len);
            idle(int'(take_bits(2)) % 3);   // zero to two idle cycles
        end
        finish_stream();
        end_test();
    endtask

    initial begin
        xclk         = 1'b0;
        rst          = 1'b1;
        code         = '0;
        code_stb     = 1'b0;
        flush_in     = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        lfsr         = 32'h2574eff6;
        cur_test     = "startup";
        start_stream();

        reset_quiet();
        if (!timed_out) begin
            plain_bytes();
        end
        if (!timed_out) begin
            lane_escapes();
        end
        if (!timed_out) begin
            boundary_escapes();
        end
        if (!timed_out) begin
            partial_flush();
        end
        if (!timed_out) begin
            random_stream();
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
rtl/stuffer_pkg.sv
rtl/byte_lane_fifo.sv
rtl/code_packer.sv
rtl/bit_stuffer_escape.sv
rtl/entropy_out_top.sv
bench/tb_entropy_out.sv

// File: include/stuffer_macros.svh
// shared sizes of the entropy output stage, include wherever a code width or lane depth is needed
`ifndef STUFFER_MACROS_SVH
`define STUFFER_MACROS_SVH

// longest Huffman code in bits
`define CODE_W 16

// width of the code length field
`define LEN_W 5

// entries per escaper byte lane
`define LANE_DEPTH 4

// pointer width for one lane
`define LANE_AW 2

// cycle limit for bench wait loops
`define WAIT_LIMIT 2000

`endif

// File: rtl/bit_stuffer_escape.sv
// escapes every 0xFF in the packed stream with a following 0x00 and realigns to 32-bit words
`timescale 1ns/1ps
`default_nettype none

module bit_stuffer_escape import stuffer_pkg::*; (
    input  logic         xclk,
    input  logic         rst,
    input  packed_word_t din,
    input  logic         in_stb,
    input  logic         flush_in,
    output packed_word_t d_out,
    output logic         dv,
    output logic         flush_out
);
    logic [3:0]  in_mask;       // lanes holding a valid input byte
    logic [3:0]  lane_we;
    logic [3:0]  lane_re;
    logic [3:0]  lane_ff;       // head byte of the lane is 0xFF
    logic [3:0]  lane_nempty;
    logic [7:0]  lane_data [4];

    logic        cry_ff;        // zero still owed after a 0xFF
    logic [1:0]  byte_pntr;     // 0 points at lane 3
    logic [31:0] out_bytes;
    logic [3:0]  pos_rdy;       // output positions that have a byte
    logic [3:0]  rd_mask;       // lanes consumed by a full word
    logic [2:0]  n_used;        // source bytes in a full word
    logic        cry_next;
    logic        rdy;
    logic [1:0]  part_cnt;
    logic        flush_req;     // flush waiting for full words to drain
    logic        flush_rd;      // read-all cycle
    logic        flush_dly;
    logic        flush_emit;
    logic        stream_done;   // closed by flush_out with no input since

    always_comb begin
        case (din.nbytes)
            2'd1:    in_mask = 4'b1000;
            2'd2:    in_mask = 4'b1100;
            2'd3:    in_mask = 4'b1110;
            default: in_mask = 4'b1111;
        endcase
    end

    assign lane_we = in_stb ? in_mask : 4'b0000;

    for (genvar i = 0; i < 4; i++) begin : g_lane
        logic [8:0] q;

        byte_lane_fifo lane_fifo_inst (
            .xclk     (xclk),
            .rst      (rst),
            .we       (lane_we[i]),
            .re       (lane_re[i]),
            .data_in  ({&din.data[8*i +: 8], din.data[8*i +: 8]}),
            .data_out (q),
            .nempty   (lane_nempty[i])
        );

        assign lane_ff[i]   = q[8];
        assign lane_data[i] = q[7:0];
    end

    // each output position from the MSB takes the next lane byte or an escape zero
    always_comb begin : walk
        logic [1:0] lane;
        logic       esc;
        lane    = 2'd3 - byte_pntr;
        esc     = cry_ff;
        n_used  = 3'd0;
        rd_mask = 4'b0000;
        for (int k = 3; k >= 0; k--) begin
            if (esc) begin
                out_bytes[8*k +: 8] = 8'h00;   // inserted zero
                pos_rdy[k]          = 1'b1;
                esc                 = 1'b0;
            end else begin
                out_bytes[8*k +: 8] = lane_data[lane];
                pos_rdy[k]          = lane_nempty[lane];
                esc                 = lane_ff[lane];
                rd_mask[lane]       = 1'b1;
                lane                = lane - 2'd1;
                n_used              = n_used + 3'd1;
            end
        end
        cry_next = esc;
    end

    assign rdy        = &pos_rdy;
    assign flush_emit = flush_rd && (cry_ff || (|lane_nempty));
    // when flushing everything left goes out at once
    assign lane_re    = flush_rd ? lane_nempty : (rdy ? rd_mask : 4'b0000);

    // leading ready positions give the partial count
    always_comb begin
        casez (pos_rdy)
            4'b10??: part_cnt = 2'd1;
            4'b110?: part_cnt = 2'd2;
            4'b1110: part_cnt = 2'd3;
            default: part_cnt = 2'd0;   // full word
        endcase
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            cry_ff      <= 1'b0;
            byte_pntr   <= 2'd0;
            dv          <= 1'b0;
            flush_req   <= 1'b0;
            flush_rd    <= 1'b0;
            flush_dly   <= 1'b0;
            flush_out   <= 1'b0;
            stream_done <= 1'b0;
        end else begin
            dv        <= rdy || flush_emit;
            flush_rd  <= flush_req && !flush_rd && !rdy;
            flush_dly <= flush_rd;
            flush_out <= flush_dly;
            if (flush_rd) begin
                cry_ff    <= 1'b0;
                byte_pntr <= 2'd0;                      // next stream starts on lane 3
            end else if (rdy) begin
                cry_ff    <= cry_next;
                byte_pntr <= byte_pntr + n_used[1:0];   // four wraps to same lane
            end
            if (flush_in) begin
                flush_req <= 1'b1;
            end else if (flush_rd) begin
                flush_req <= 1'b0;
            end
            if (in_stb) begin
                stream_done <= 1'b0;
            end else if (flush_out) begin
                stream_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (rdy || flush_emit) begin
            d_out.data   <= out_bytes;
            d_out.nbytes <= part_cnt;
        end
    end

    // while bytes wait the pointer names the lane that holds the oldest one
    pntr_at_oldest: assert property (@(posedge xclk) disable iff (rst)
        (|lane_nempty) |-> lane_nempty[2'd3 - byte_pntr]);

    // once a stream is closed nothing more comes out until new input arrives
    no_dv_after_flush: assert property (@(posedge xclk) disable iff (rst)
        (flush_out || stream_done) |-> !dv);

endmodule

`default_nettype wire

// File: rtl/byte_lane_fifo.sv
// small FIFO for one escaper byte lane, the head entry is shown on data_out before it is read
`timescale 1ns/1ps
`default_nettype none

`include "stuffer_macros.svh"

module byte_lane_fifo (
    input  logic       xclk,
    input  logic       rst,
    input  logic       we,
    input  logic       re,
    input  logic [8:0] data_in,   // {is 0xFF, byte}
    output logic [8:0] data_out,
    output logic       nempty
);
    logic [8:0]          mem [`LANE_DEPTH];
    logic [`LANE_AW-1:0] wr_ptr;
    logic [`LANE_AW-1:0] rd_ptr;
    logic [`LANE_AW:0]   count;     // entries held

    assign data_out = mem[rd_ptr];  // first word fall-through
    assign nempty   = (count != '0);

    always_ff @(posedge xclk) begin
        if (we) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (we) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (re) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({we, re})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or both
            endcase
        end
    end

    // the upstream rate limit is what keeps a lane from overflowing
    no_overflow: assert property (@(posedge xclk) disable iff (rst)
        we |-> (count != `LANE_DEPTH));

    no_underflow: assert property (@(posedge xclk) disable iff (rst)
        re |-> nempty);

endmodule

`default_nettype wire

// File: rtl/code_packer.sv
// packs variable-length codes MSB first into 32-bit words, flush emits a ones-padded partial word
`timescale 1ns/1ps
`default_nettype none

`include "stuffer_macros.svh"

module code_packer import stuffer_pkg::*; (
    input  logic         xclk,
    input  logic         rst,
    input  code_in_t     code,
    input  logic         code_stb,
    input  logic         flush_in,
    output packed_word_t pk_word,
    output logic         pk_stb,
    output logic         pk_flush
);
    logic [63:0] acc;         // pending bits, left aligned, zeros below fill
    logic [5:0]  fill;        // pending bit count, always below 32 between codes
    logic [4:0]  lalign;      // shift that puts the code MSB at bit 63
    logic [63:0] placed;      // new code just below the pending bits
    logic [63:0] acc_sum;
    logic [5:0]  fill_sum;
    logic [5:0]  fill_rnd;    // for rounding up to whole bytes
    logic        flush_wait;  // partial word out, pk_flush next

    assign lalign   = 5'(`CODE_W) - code.len;
    assign placed   = ({code.bits, {(64 - `CODE_W){1'b0}}} << lalign) >> fill;
    assign acc_sum  = acc | placed;
    assign fill_sum = fill + 6'(code.len);
    assign fill_rnd = fill + 6'd7;

    always_ff @(posedge xclk) begin
        if (rst) begin
            acc        <= '0;
            fill       <= '0;
            pk_stb     <= 1'b0;
            pk_flush   <= 1'b0;
            flush_wait <= 1'b0;
        end else begin
            pk_stb     <= 1'b0;
            flush_wait <= flush_in && (fill != 6'd0);
            pk_flush   <= (flush_in && (fill == 6'd0)) || flush_wait;
            if (code_stb) begin
                if (fill_sum[5]) begin                  // 32 or more bits
                    acc    <= {acc_sum[31:0], 32'h0};   // remainder moves up
                    fill   <= fill_sum - 6'd32;
                    pk_stb <= 1'b1;
                end else begin
                    acc  <= acc_sum;
                    fill <= fill_sum;
                end
            end else if (flush_in && (fill != 6'd0)) begin
                acc    <= '0;
                fill   <= '0;
                pk_stb <= 1'b1;                         // partial word
            end
        end
    end

    // word contents, qualified by pk_stb
    always_ff @(posedge xclk) begin
        if (code_stb) begin
            pk_word.data   <= acc_sum[63:32];
            pk_word.nbytes <= 2'd0;
        end else if (flush_in) begin
            // JPEG pads the last byte with ones
            pk_word.data   <= acc[63:32] | (32'hffff_ffff >> fill);
            pk_word.nbytes <= fill_rnd[4:3];            // 25 to 31 bits wrap to 0
        end
    end

    // the caller must never present an empty or oversized code
    code_len_ok: assert property (@(posedge xclk) disable iff (rst)
        code_stb |-> (code.len != '0) && (code.len <= `CODE_W));

endmodule

`default_nettype wire

// File: rtl/entropy_out_top.sv
// entropy output stage top, code packer feeding the 0xFF escaper
`timescale 1ns/1ps
`default_nettype none

module entropy_out_top import stuffer_pkg::*; (
    input  logic         xclk,
    input  logic         rst,
    input  code_in_t     code,
    input  logic         code_stb,
    input  logic         flush_in,
    output packed_word_t esc_word,
    output logic         dv,
    output logic         flush_out
);
    packed_word_t pk_word;    // packed words before escaping
    logic         pk_stb;
    logic         pk_flush;

    code_packer code_packer_inst (
        .xclk     (xclk),
        .rst      (rst),
        .code     (code),
        .code_stb (code_stb),
        .flush_in (flush_in),
        .pk_word  (pk_word),
        .pk_stb   (pk_stb),
        .pk_flush (pk_flush)
    );

    bit_stuffer_escape bit_stuffer_escape_inst (
        .xclk      (xclk),
        .rst       (rst),
        .din       (pk_word),
        .in_stb    (pk_stb),
        .flush_in  (pk_flush),
        .d_out     (esc_word),
        .dv        (dv),
        .flush_out (flush_out)
    );

endmodule

`default_nettype wire

// File: rtl/stuffer_pkg.sv
// types passed between the code packer, the escaper and the top level, import where a port needs them
`default_nettype none

`include "stuffer_macros.svh"

package stuffer_pkg;

    // one 32-bit word of the compressed stream
    typedef struct packed {
        logic [31:0] data;    // MSB aligned, first byte in [31:24]
        logic [1:0]  nbytes;  // leading valid bytes, 0 means all four
    } packed_word_t;

    // one variable-length code
    typedef struct packed {
        logic [`CODE_W-1:0] bits;  // right aligned
        logic [`LEN_W-1:0]  len;   // 1 to CODE_W
    } code_in_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the entropy output stage with Verilator and runs the testbench.
# Exits non-zero when the build, the run or the final check fails.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log
TOP=tb_entropy_out

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f files.f \
    --Mdir "$BUILD_DIR" -o "$TOP" > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST OK" "$SIM_LOG"; then
    exit 0
fi
echo "pass line not found in $SIM_LOG"
exit 1
